// File: files.f
+incdir+sim
source/cpu_pkg.sv
source/reg_file.sv
source/inst_decoder.sv
source/operand_select.sv
source/id_stage.sv
sim/tb_id_stage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f files.f --top-module tb_id_stage -o tb_id_stage
./obj_dir/tb_id_stage > sim.log 2>&1 || true
cat sim.log
if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: sim/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

typedef word_t [NUM_REGS-1:0] reg_bank_t;

typedef struct packed {
    alu_op_t   aluop;
    alu_sel_t  alusel;
    reg_addr_t wd;
    logic      wreg;
    word_t     op1;
    word_t     op2;
} expect_t;

// right-shifting galois form, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic reg_bank_t bank_write(input reg_bank_t bank, input logic we,
                                         input reg_addr_t addr, input word_t data);
    reg_bank_t b;
    b = bank;
    if (we && (addr != '0)) begin
        b[addr] = data;
    end
    return b;
endfunction

// forwards first, then the bank with same-cycle write-back
function automatic word_t resolve_operand(
    input logic rd_on, input reg_addr_t addr, input word_t imm,
    input logic ex_we, input reg_addr_t ex_addr, input word_t ex_data,
    input logic mem_we, input reg_addr_t mem_addr, input word_t mem_data,
    input logic wb_we, input reg_addr_t wb_addr, input word_t wb_data,
    input reg_bank_t bank
);
    word_t v;
    if (!rd_on) begin
        v = imm;
    end else if (addr == '0) begin
        v = '0;
    end else if (ex_we && (ex_addr == addr)) begin
        v = ex_data;
    end else if (mem_we && (mem_addr == addr)) begin
        v = mem_data;
    end else if (wb_we && (wb_addr == addr)) begin
        v = wb_data;
    end else begin
        v = bank[addr];
    end
    return v;
endfunction

function automatic expect_t ref_decode(
    input logic arst_n, input inst_t inst,
    input logic ex_we, input reg_addr_t ex_addr, input word_t ex_data,
    input logic mem_we, input reg_addr_t mem_addr, input word_t mem_data,
    input logic wb_we, input reg_addr_t wb_addr, input word_t wb_data,
    input reg_bank_t bank
);
    expect_t e;
    logic    rd1;
    logic    rd2;
    word_t   imm;
    e        = '0;
    e.aluop  = OP_NOP;
    e.alusel = RES_NOP;
    e.wd     = inst.r.rd;
    rd1      = 1'b0;
    rd2      = 1'b0;
    imm      = '0;
    if (!arst_n) begin
        return e;
    end
    if ((inst.r.opcode == OPC_SPECIAL) && (inst.r.shamt == '0) &&
        (inst.r.funct inside {FN_OR, FN_AND, FN_XOR, FN_NOR, FN_SLLV, FN_SRLV, FN_SRAV})) begin
        rd1      = 1'b1;
        rd2      = 1'b1;
        e.alusel = (inst.r.funct inside {FN_OR, FN_AND, FN_XOR, FN_NOR}) ? RES_LOGIC : RES_SHIFT;
        case (inst.r.funct)
            FN_OR:   e.aluop = OP_OR;
            FN_AND:  e.aluop = OP_AND;
            FN_XOR:  e.aluop = OP_XOR;
            FN_NOR:  e.aluop = OP_NOR;
            FN_SLLV: e.aluop = OP_SLL;
            FN_SRLV: e.aluop = OP_SRL;
            default: e.aluop = OP_SRA;
        endcase
    end else if ((inst.r.opcode == OPC_SPECIAL) && (inst.r.rs == '0) &&
                 (inst.r.funct inside {FN_SLL, FN_SRL, FN_SRA})) begin
        rd2      = 1'b1;
        imm      = {27'd0, inst.r.shamt};
        e.alusel = RES_SHIFT;
        e.aluop  = (inst.r.funct == FN_SLL) ? OP_SLL :
                   ((inst.r.funct == FN_SRL) ? OP_SRL : OP_SRA);
    end else if (inst.i.opcode inside {OPC_ORI, OPC_ANDI, OPC_XORI, OPC_LUI}) begin
        rd1      = 1'b1;
        e.wd     = inst.i.rt;
        e.alusel = RES_LOGIC;
        imm      = (inst.i.opcode == OPC_LUI) ? {inst.i.imm16, 16'h0000} :
                                                {16'h0000, inst.i.imm16};
        case (inst.i.opcode)
            OPC_ANDI: e.aluop = OP_AND;
            OPC_XORI: e.aluop = OP_XOR;
            default:  e.aluop = OP_OR;  // ori and lui
        endcase
    end
    e.wreg = (e.alusel != RES_NOP);
    e.op1  = resolve_operand(rd1, inst.r.rs, imm, ex_we, ex_addr, ex_data,
                             mem_we, mem_addr, mem_data, wb_we, wb_addr, wb_data, bank);
    e.op2  = resolve_operand(rd2, inst.r.rt, imm, ex_we, ex_addr, ex_data,
                             mem_we, mem_addr, mem_data, wb_we, wb_addr, wb_data, bank);
    return e;
endfunction

`endif

// File: sim/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage import cpu_pkg::*; ();

    `include "tb_ref.svh"

    localparam int RESET_CYCLES = 10;
    localparam int N_FILL       = 40;
    localparam int N_REG        = 160;
    localparam int N_IMM        = 120;
    localparam int N_SHIFT      = 80;
    localparam int N_FWD        = 200;
    localparam int N_BAD        = 100;
    localparam int TEST_CYCLES  = N_FILL + N_REG + N_IMM + N_SHIFT + N_FWD + N_BAD;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES + 20) * 10;

    localparam logic [5:0] REG_FNS [7] = '{FN_OR, FN_AND, FN_XOR, FN_NOR,
                                           FN_SLLV, FN_SRLV, FN_SRAV};
    localparam logic [5:0] SHIFT_FNS [3] = '{FN_SLL, FN_SRL, FN_SRA};
    localparam logic [5:0] IMM_OPCS [4] = '{OPC_ORI, OPC_ANDI, OPC_XORI, OPC_LUI};
    // mfhi mthi mflo mtlo movz movn sync
    localparam logic [5:0] DROP_FNS [7] = '{6'b010000, 6'b010001, 6'b010010, 6'b010011,
                                            6'b001010, 6'b001011, 6'b001111};

    logic      clk = 1'b0;
    logic      arst_n;
    word_t     inst_w;
    logic      ex_we;
    reg_addr_t ex_addr;
    word_t     ex_data;
    logic      mem_we;
    reg_addr_t mem_addr;
    word_t     mem_data;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;
    alu_op_t   aluop;
    alu_sel_t  alusel;
    word_t     op1;
    word_t     op2;
    reg_addr_t wd;
    logic      wreg;

    logic [15:0] lfsr_state;
    logic        check_en;
    int          n_checks = 0;
    reg_bank_t   shadow = '0;
    expect_t     expected;

    id_stage dut_i (
        .clk        (clk),
        .arst_n_i   (arst_n),
        .inst_i     (inst_w),
        .ex_we_i    (ex_we),
        .ex_addr_i  (ex_addr),
        .ex_data_i  (ex_data),
        .mem_we_i   (mem_we),
        .mem_addr_i (mem_addr),
        .mem_data_i (mem_data),
        .wb_we_i    (wb_we),
        .wb_addr_i  (wb_addr),
        .wb_data_i  (wb_data),
        .aluop_o    (aluop),
        .alusel_o   (alusel),
        .op1_o      (op1),
        .op2_o      (op2),
        .wd_o       (wd),
        .wreg_o     (wreg)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] v;
        v = rand_bits(1);
        return v[0];
    endfunction

    function automatic reg_addr_t rand_addr();
        return reg_addr_t'(rand_bits(5));
    endfunction

    function automatic int rand_index(input int n);
        return int'(rand_bits(8) % n);
    endfunction

    function automatic inst_t make_r(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] shamt,
                                     input logic [5:0] funct);
        inst_t w;
        w.r = '{OPC_SPECIAL, rs, rt, rd, shamt, funct};
        return w;
    endfunction

    function automatic inst_t make_i(input logic [5:0] opc, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        inst_t w;
        w.i = '{opc, rs, rt, imm};
        return w;
    endfunction

    task automatic next_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_env(input logic ex_on, input logic mem_on, input logic wb_on);
        ex_we    = ex_on;
        ex_addr  = rand_addr();
        ex_data  = rand_bits(32);
        mem_we   = mem_on;
        mem_addr = rand_addr();
        mem_data = rand_bits(32);
        wb_we    = wb_on;
        wb_addr  = rand_addr();
        wb_data  = rand_bits(32);
    endtask

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "decode mismatch");
    endtask

    task automatic check_alu(input alu_op_t got_op, input alu_sel_t got_sel,
                             input alu_op_t want_op, input alu_sel_t want_sel);
        if ((got_op !== want_op) || (got_sel !== want_sel)) begin
            $display("FAIL %0t: inst %h aluop/alusel %h/%h, expected %h/%h",
                     $time, inst_w, got_op, got_sel, want_op, want_sel);
            abort_run();
        end
    endtask

    task automatic check_word(input word_t got, input word_t want, input string what);
        if (got !== want) begin
            $display("FAIL %0t: inst %h %s is %h, expected %h",
                     $time, inst_w, what, got, want);
            abort_run();
        end
    endtask

    task automatic check_dest(input reg_addr_t got_wd, input logic got_we,
                              input reg_addr_t want_wd, input logic want_we);
        if ((got_wd !== want_wd) || (got_we !== want_we)) begin
            $display("FAIL %0t: inst %h wd/wreg %0d/%b, expected %0d/%b",
                     $time, inst_w, got_wd, got_we, want_wd, want_we);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        #5;
        if (check_en) begin
            expected = ref_decode(arst_n, inst_t'(inst_w), ex_we, ex_addr, ex_data,
                                  mem_we, mem_addr, mem_data, wb_we, wb_addr, wb_data, shadow);
            check_alu(aluop, alusel, expected.aluop, expected.alusel);
            check_word(op1, expected.op1, "op1");
            check_word(op2, expected.op2, "op2");
            check_dest(wd, wreg, expected.wd, expected.wreg);
            n_checks++;
            shadow = arst_n ? bank_write(shadow, wb_we, wb_addr, wb_data) : '0;  // next edge
        end
    end

    initial begin
        reg_addr_t rs;
        reg_addr_t rt;
        arst_n     = 1'b0;
        inst_w     = '0;
        lfsr_state = 16'd61798;
        check_en   = 1'b0;
        ex_we      = 1'b0;
        ex_addr    = '0;
        ex_data    = '0;
        mem_we     = 1'b0;
        mem_addr   = '0;
        mem_data   = '0;
        wb_we      = 1'b0;
        wb_addr    = '0;
        wb_data    = '0;

        repeat (RESET_CYCLES) begin  // valid words must still look like a no-op
            next_slot();
            check_en = 1'b1;
            if (rand_bit()) begin
                inst_w = make_r(rand_addr(), rand_addr(), rand_addr(), 5'd0,
                                REG_FNS[rand_index(7)]);
            end else begin
                inst_w = make_i(IMM_OPCS[rand_index(4)], rand_addr(), rand_addr(),
                                16'(rand_bits(16)));
            end
            drive_env(rand_bit(), rand_bit(), rand_bit());
        end

        repeat (N_FILL) begin
            next_slot();
            arst_n = 1'b1;
            inst_w = make_r(rand_addr(), rand_addr(), rand_addr(), 5'd0, REG_FNS[rand_index(7)]);
            drive_env(1'b0, 1'b0, 1'b1);
        end

        repeat (N_REG) begin
            next_slot();
            rs = rand_addr();
            rt = rand_addr();
            inst_w = make_r(rs, rt, rand_addr(), 5'd0, REG_FNS[rand_index(7)]);
            drive_env(1'b0, 1'b0, rand_bit());
            if (rand_bit()) begin
                wb_addr = rand_bit() ? rs : rt;  // write-through
            end
        end

        repeat (N_IMM) begin
            next_slot();
            rs = rand_addr();
            inst_w = make_i(IMM_OPCS[rand_index(4)], rs, rand_addr(), 16'(rand_bits(16)));
            drive_env(1'b0, 1'b0, rand_bit());
            if (rand_bit()) begin
                wb_addr = rs;
            end
        end

        repeat (N_SHIFT) begin
            next_slot();
            rt = rand_addr();
            inst_w = make_r(5'd0, rt, rand_addr(), rand_addr(), SHIFT_FNS[rand_index(3)]);
            drive_env(1'b0, 1'b0, rand_bit());
            if (rand_bit()) begin
                wb_addr = rt;
            end
        end

        repeat (N_FWD) begin
            next_slot();
            rs = (rand_bits(3) == 0) ? 5'd0 : rand_addr();  // r0 now and then
            rt = rand_addr();
            if (rand_bit()) begin
                inst_w = make_r(rs, rt, rand_addr(), 5'd0, REG_FNS[rand_index(7)]);
            end else begin
                inst_w = make_i(IMM_OPCS[rand_index(4)], rs, rt, 16'(rand_bits(16)));
            end
            drive_env(rand_bit(), rand_bit(), rand_bit());
            if (rand_bits(2) != 0) begin
                ex_addr = rand_bit() ? rs : rt;
            end
            if (rand_bits(2) != 0) begin
                mem_addr = rand_bit() ? rs : rt;  // often both stages hit one source
            end
            if (rand_bit()) begin
                wb_addr = rt;
            end
        end

        repeat (N_BAD) begin
            next_slot();
            case (rand_index(5))
                0: inst_w = make_r(rand_addr(), rand_addr(), rand_addr(), 5'd0,
                                   DROP_FNS[rand_index(7)]);
                1: inst_w = make_i({2'b11, 4'(rand_bits(4))}, rand_addr(), rand_addr(),
                                   16'(rand_bits(16)));  // pref and friends
                2: inst_w = make_i({2'b10, 4'(rand_bits(4))}, rand_addr(), rand_addr(),
                                   16'(rand_bits(16)));  // loads, stores
                3: inst_w = make_r(rand_addr(), rand_addr(), rand_addr(), rand_addr() | 5'd1,
                                   REG_FNS[rand_index(7)]);
                default: inst_w = make_r(rand_addr() | 5'd1, rand_addr(), rand_addr(),
                                         rand_addr(), SHIFT_FNS[rand_index(3)]);
            endcase
            drive_env(rand_bit(), rand_bit(), rand_bit());
        end

        next_slot();
        check_en = 1'b0;
        if (n_checks == RESET_CYCLES + TEST_CYCLES) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("compare process ran %0d checks instead of %0d",
                     n_checks, RESET_CYCLES + TEST_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "check count mismatch");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: the run timed out after %0d ns without finishing", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

endmodule

// File: source/id_stage.sv
`timescale 1ns/1ps

module id_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  word_t     inst_i,
    input  logic      ex_we_i,
    input  reg_addr_t ex_addr_i,
    input  word_t     ex_data_i,
    input  logic      mem_we_i,
    input  reg_addr_t mem_addr_i,
    input  word_t     mem_data_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_addr_i,
    input  word_t     wb_data_i,
    output alu_op_t   aluop_o,
    output alu_sel_t  alusel_o,
    output word_t     op1_o,
    output word_t     op2_o,
    output reg_addr_t wd_o,
    output logic      wreg_o
);

    logic      re1;
    logic      re2;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     imm;
    word_t     rdata1;
    word_t     rdata2;

    inst_decoder decoder_i (
        .arst_n_i (arst_n_i),
        .inst_i   (inst_i),
        .re1_o    (re1),
        .re2_o    (re2),
        .raddr1_o (raddr1),
        .raddr2_o (raddr2),
        .imm_o    (imm),
        .aluop_o  (aluop_o),
        .alusel_o (alusel_o),
        .wd_o     (wd_o),
        .wreg_o   (wreg_o)
    );

    reg_file regs_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .re1_i    (re1),
        .re2_i    (re2),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .we_i     (wb_we_i),  // write-back port
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    operand_select op1_sel (
        .arst_n_i   (arst_n_i),
        .re_i       (re1),
        .raddr_i    (raddr1),
        .rdata_i    (rdata1),
        .imm_i      (imm),
        .ex_we_i    (ex_we_i),
        .ex_addr_i  (ex_addr_i),
        .ex_data_i  (ex_data_i),
        .mem_we_i   (mem_we_i),
        .mem_addr_i (mem_addr_i),
        .mem_data_i (mem_data_i),
        .op_o       (op1_o)
    );

    operand_select op2_sel (
        .arst_n_i   (arst_n_i),
        .re_i       (re2),
        .raddr_i    (raddr2),
        .rdata_i    (rdata2),
        .imm_i      (imm),
        .ex_we_i    (ex_we_i),
        .ex_addr_i  (ex_addr_i),
        .ex_data_i  (ex_data_i),
        .mem_we_i   (mem_we_i),
        .mem_addr_i (mem_addr_i),
        .mem_data_i (mem_data_i),
        .op_o       (op2_o)
    );

endmodule

// File: source/operand_select.sv
`timescale 1ns/1ps

module operand_select import cpu_pkg::*; (
    input  logic      arst_n_i,
    input  logic      re_i,
    input  reg_addr_t raddr_i,
    input  word_t     rdata_i,
    input  word_t     imm_i,
    input  logic      ex_we_i,
    input  reg_addr_t ex_addr_i,
    input  word_t     ex_data_i,
    input  logic      mem_we_i,
    input  reg_addr_t mem_addr_i,
    input  word_t     mem_data_i,
    output word_t     op_o
);

    logic fwd_ok;
    logic ex_hit;
    logic mem_hit;

    assign fwd_ok  = re_i && (raddr_i != '0);  // r0 is never forwarded
    assign ex_hit  = fwd_ok && ex_we_i && (ex_addr_i == raddr_i);
    assign mem_hit = fwd_ok && mem_we_i && (mem_addr_i == raddr_i);

    always_comb begin
        if (!arst_n_i) begin
            op_o = '0;
        end else if (ex_hit) begin
            op_o = ex_data_i;  // youngest result wins
        end else if (mem_hit) begin
            op_o = mem_data_i;
        end else if (re_i) begin
            op_o = rdata_i;
        end else begin
            op_o = imm_i;
        end
    end

endmodule

// File: source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import cpu_pkg::*; (
    input  logic      arst_n_i,
    input  inst_t     inst_i,
    output logic      re1_o,
    output logic      re2_o,
    output reg_addr_t raddr1_o,
    output reg_addr_t raddr2_o,
    output word_t     imm_o,
    output alu_op_t   aluop_o,
    output alu_sel_t  alusel_o,
    output reg_addr_t wd_o,
    output logic      wreg_o
);

    logic is_special;
    logic shift_imm_form;

    assign is_special     = (inst_i.r.opcode == OPC_SPECIAL);
    assign shift_imm_form = is_special && (inst_i.r.rs == '0);  // top eleven bits clear

    always_comb begin
        re1_o    = 1'b0;
        re2_o    = 1'b0;
        raddr1_o = inst_i.r.rs;
        raddr2_o = inst_i.r.rt;
        imm_o    = '0;
        aluop_o  = OP_NOP;
        alusel_o = RES_NOP;
        wd_o     = inst_i.r.rd;
        wreg_o   = 1'b0;

        if (!arst_n_i) begin
            // keep the no-op defaults
        end else if (is_special) begin
            if (inst_i.r.shamt == '0) begin
                case (inst_i.r.funct)
                    FN_OR: begin
                        aluop_o  = OP_OR;
                        alusel_o = RES_LOGIC;
                    end
                    FN_AND: begin
                        aluop_o  = OP_AND;
                        alusel_o = RES_LOGIC;
                    end
                    FN_XOR: begin
                        aluop_o  = OP_XOR;
                        alusel_o = RES_LOGIC;
                    end
                    FN_NOR: begin
                        aluop_o  = OP_NOR;
                        alusel_o = RES_LOGIC;
                    end
                    FN_SLLV: begin
                        aluop_o  = OP_SLL;
                        alusel_o = RES_SHIFT;
                    end
                    FN_SRLV: begin
                        aluop_o  = OP_SRL;
                        alusel_o = RES_SHIFT;
                    end
                    FN_SRAV: begin
                        aluop_o  = OP_SRA;
                        alusel_o = RES_SHIFT;
                    end
                    default: begin
                    end
                endcase
                if (alusel_o != RES_NOP) begin  // rs op rt into rd
                    re1_o  = 1'b1;
                    re2_o  = 1'b1;
                    wreg_o = 1'b1;
                end
            end

            if (shift_imm_form) begin
                case (inst_i.r.funct)
                    FN_SLL: begin
                        aluop_o  = OP_SLL;
                        alusel_o = RES_SHIFT;
                    end
                    FN_SRL: begin
                        aluop_o  = OP_SRL;
                        alusel_o = RES_SHIFT;
                    end
                    FN_SRA: begin
                        aluop_o  = OP_SRA;
                        alusel_o = RES_SHIFT;
                    end
                    default: begin
                    end
                endcase
                if ((inst_i.r.funct == FN_SLL) || (inst_i.r.funct == FN_SRL) ||
                    (inst_i.r.funct == FN_SRA)) begin
                    re2_o      = 1'b1;
                    wreg_o     = 1'b1;
                    imm_o[4:0] = inst_i.r.shamt;  // shift amount as operand 1
                end
            end
        end else begin
            case (inst_i.i.opcode)
                OPC_ORI: begin
                    aluop_o  = OP_OR;
                    alusel_o = RES_LOGIC;
                    imm_o    = {16'h0000, inst_i.i.imm16};
                end
                OPC_ANDI: begin
                    aluop_o  = OP_AND;
                    alusel_o = RES_LOGIC;
                    imm_o    = {16'h0000, inst_i.i.imm16};
                end
                OPC_XORI: begin
                    aluop_o  = OP_XOR;
                    alusel_o = RES_LOGIC;
                    imm_o    = {16'h0000, inst_i.i.imm16};
                end
                OPC_LUI: begin
                    aluop_o  = OP_OR;  // rs | upper imm
                    alusel_o = RES_LOGIC;
                    imm_o    = {inst_i.i.imm16, 16'h0000};
                end
                default: begin
                end
            endcase
            if (alusel_o != RES_NOP) begin
                re1_o  = 1'b1;
                wd_o   = inst_i.i.rt;  // immediate forms target rt
                wreg_o = 1'b1;
            end
        end
    end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      re1_i,
    input  logic      re2_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin  // r0 never stored
            regs[waddr_i] <= wdata_i;
        end
    end

    // one read port with write-through
    function automatic word_t read_port(
        input logic      re,
        input reg_addr_t raddr,
        input word_t     stored,
        input logic      we,
        input reg_addr_t waddr,
        input word_t     wdata
    );
        word_t rdata;
        if (!re || (raddr == '0)) begin
            rdata = '0;
        end else if (we && (waddr == raddr)) begin
            rdata = wdata;  // same-cycle write-back
        end else begin
            rdata = stored;
        end
        return rdata;
    endfunction

    assign rdata1_o = read_port(re1_i, raddr1_i, regs[raddr1_i], we_i, waddr_i, wdata_i);
    assign rdata2_o = read_port(re2_i, raddr2_i, regs[raddr2_i], we_i, waddr_i, wdata_i);

endmodule

// File: source/cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 5;
    localparam int NUM_REGS = 32;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] reg_addr_t;
    typedef logic [7:0]        alu_op_t;   // operation subclass
    typedef logic [2:0]        alu_sel_t;  // operation class

    // register form, used under SPECIAL
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_fields_t;

    // one instruction word, two views
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_t;

    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_ANDI    = 6'b001100;
    localparam logic [5:0] OPC_ORI     = 6'b001101;
    localparam logic [5:0] OPC_XORI    = 6'b001110;
    localparam logic [5:0] OPC_LUI     = 6'b001111;

    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;

    localparam alu_op_t OP_NOP = 8'b0000_0000;
    localparam alu_op_t OP_SRL = 8'b0000_0010;
    localparam alu_op_t OP_SRA = 8'b0000_0011;
    localparam alu_op_t OP_AND = 8'b0010_0100;
    localparam alu_op_t OP_OR  = 8'b0010_0101;
    localparam alu_op_t OP_XOR = 8'b0010_0110;
    localparam alu_op_t OP_NOR = 8'b0010_0111;
    localparam alu_op_t OP_SLL = 8'b0111_1100;

    localparam alu_sel_t RES_NOP   = 3'b000;
    localparam alu_sel_t RES_LOGIC = 3'b001;
    localparam alu_sel_t RES_SHIFT = 3'b010;

endpackage
